// File: all.f
axi_pkg.sv
axi_master_driver.sv
axi_write_channel.sv
axi_read_channel.sv
axi_master.sv
tb_axi_slave.sv
tb_axi_master.sv

// File: run.sh
#!/bin/sh

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -f all.f --top-module tb_axi_master -o sim_axi_master; then
    echo "verilator build failed"
    exit 1
fi

if ! ./obj_dir/sim_axi_master; then
    echo "simulation failed"
    exit 1
fi

exit 0

// File: tb_axi_master.sv
`timescale 1ns/1ns

module tb_axi_master;

    localparam int             MEM_WORDS = 256;
    localparam int             N_WRITES  = 100;
    localparam int             N_ERRORS  = 10;
    localparam int             SEED      = 32'h62ec2826;
    localparam axi_pkg::addr_t ERR_BASE  = MEM_WORDS * 4;

    logic           clk_i = 1'b0;
    logic           rst_n_i;
    logic           stall;
    axi_pkg::addr_t write_address_i;
    axi_pkg::data_t write_data_i;
    axi_pkg::strb_t write_strobe_i;
    logic           write_load_i;
    logic           write_full_o;
    logic           write_done_o;
    axi_pkg::resp_t write_resp_o;
    axi_pkg::addr_t read_address_i;
    logic           read_load_i;
    logic           read_full_o;
    logic           read_valid_o;
    axi_pkg::data_t read_data_o;
    axi_pkg::resp_t read_resp_o;
    axi_pkg::addr_t awaddr_o;
    logic           awvalid_o;
    logic           awready_i;
    axi_pkg::data_t wdata_o;
    axi_pkg::strb_t wstrb_o;
    logic           wvalid_o;
    logic           wready_i;
    logic           bvalid_i;
    axi_pkg::resp_t bresp_i;
    logic           bready_o;
    axi_pkg::addr_t araddr_o;
    logic           arvalid_o;
    logic           arready_i;
    logic           rvalid_i;
    axi_pkg::data_t rdata_i;
    axi_pkg::resp_t rresp_i;
    logic           rready_o;

    // reference model
    axi_pkg::data_t model_mem [MEM_WORDS];
    axi_pkg::resp_t exp_wr_resp [$];
    axi_pkg::resp_t exp_rd_resp [$];
    axi_pkg::data_t exp_rd_data [$];
    axi_pkg::addr_t written [$];
    axi_pkg::addr_t err_addrs [$];
    integer         seed = SEED;
    logic [31:0]    rnd;
    axi_pkg::addr_t addr;
    int             wr_issued = 0;
    int             rd_issued = 0;
    int             wr_done = 0;
    int             rd_done = 0;
    int             burst;
    int             cycles;

    axi_master i_dut (.*);

    tb_axi_slave #(.MEM_WORDS(MEM_WORDS), .SEED(SEED)) i_slave (
        .clk_i     (clk_i),
        .rst_n_i   (rst_n_i),
        .stall_i   (stall),
        .awaddr_i  (awaddr_o),
        .awvalid_i (awvalid_o),
        .awready_o (awready_i),
        .wdata_i   (wdata_o),
        .wstrb_i   (wstrb_o),
        .wvalid_i  (wvalid_o),
        .wready_o  (wready_i),
        .bvalid_o  (bvalid_i),
        .bresp_o   (bresp_i),
        .bready_i  (bready_o),
        .araddr_i  (araddr_o),
        .arvalid_i (arvalid_o),
        .arready_o (arready_i),
        .rvalid_o  (rvalid_i),
        .rdata_o   (rdata_i),
        .rresp_o   (rresp_i),
        .rready_i  (rready_o)
    );

    always #5 clk_i = ~clk_i;

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Testbench failed");
        $fatal(1, "stopped at first failure");
    endtask

    task automatic check_resp(input string name, input axi_pkg::resp_t got,
                              input axi_pkg::resp_t exp);
        if (got !== exp) abort_run($sformatf("** Error: %s is 0x%h, expected 0x%h", name, got, exp));
    endtask

    task automatic check_data(input string name, input axi_pkg::data_t got,
                              input axi_pkg::data_t exp);
        if (got !== exp) abort_run($sformatf("** Error: %s is 0x%h, expected 0x%h", name, got, exp));
    endtask

    task automatic check_level(input string name, input logic got, input logic exp);
        if (got !== exp) abort_run($sformatf("** Error: %s is 0x%h, expected 0x%h", name, got, exp));
    endtask

    // next drive slot, load pulses last one cycle
    task automatic step();
        @(posedge clk_i);
        #1;
        write_load_i = 1'b0;
        read_load_i  = 1'b0;
    endtask

    task automatic drive_write(input axi_pkg::addr_t a, input axi_pkg::data_t d,
                               input axi_pkg::strb_t s);
        write_address_i = a;
        write_data_i    = d;
        write_strobe_i  = s;
        write_load_i    = 1'b1;
        wr_issued++;
        if (a >= ERR_BASE) begin
            exp_wr_resp.push_back(axi_pkg::RESP_SLVERR);   // memory untouched
        end else begin
            exp_wr_resp.push_back(axi_pkg::RESP_OKAY);
            for (int b = 0; b < 4; b++) begin
                if (s[b]) model_mem[a[9:2]][8*b +: 8] = d[8*b +: 8];
            end
        end
    endtask

    task automatic issue_write(input axi_pkg::addr_t a, input axi_pkg::data_t d,
                               input axi_pkg::strb_t s);
        step();
        while (write_full_o) step();
        drive_write(a, d, s);
    endtask

    task automatic issue_read(input axi_pkg::addr_t a);
        step();
        while (read_full_o) step();
        read_address_i = a;
        read_load_i    = 1'b1;
        rd_issued++;
        if (a >= ERR_BASE) begin
            exp_rd_resp.push_back(axi_pkg::RESP_SLVERR);
            exp_rd_data.push_back('0);
        end else begin
            exp_rd_resp.push_back(axi_pkg::RESP_OKAY);
            exp_rd_data.push_back(model_mem[a[9:2]]);
        end
    endtask

    task automatic wait_writes();
        step();
        while (wr_done != wr_issued) @(posedge clk_i);
    endtask

    task automatic wait_reads();
        step();
        while (rd_done != rd_issued) @(posedge clk_i);
    endtask

    // done pulses sampled away from the rising edge
    always @(negedge clk_i) begin
        if (rst_n_i && write_done_o) begin
            if (exp_wr_resp.size() == 0) begin
                abort_run("write_done_o pulsed with no write request outstanding");
            end else begin
                check_resp("write_resp_o", write_resp_o, exp_wr_resp.pop_front());
                wr_done++;
            end
        end
        if (rst_n_i && read_valid_o) begin
            if (exp_rd_resp.size() == 0) begin
                abort_run("read_valid_o pulsed with no read request outstanding");
            end else begin
                check_resp("read_resp_o", read_resp_o, exp_rd_resp.pop_front());
                check_data("read_data_o", read_data_o, exp_rd_data.pop_front());
                rd_done++;
            end
        end
    end

    // budget grows with every request issued
    initial begin
        cycles = 0;
        while (cycles <= 200 * (wr_issued + rd_issued + 1)) begin
            @(posedge clk_i);
            cycles++;
        end
        $display("timeout: the DUT did not finish its requests in time");
        $display("Testbench failed");
        $fatal(1, "watchdog expired");
    end

    initial begin
        rst_n_i         = 1'b0;
        stall           = 1'b0;
        write_address_i = '0;
        write_data_i    = '0;
        write_strobe_i  = '0;
        write_load_i    = 1'b0;
        read_address_i  = '0;
        read_load_i     = 1'b0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            model_mem[i] = {16'hc0de, i[7:0], ~i[7:0]};   // same fill as the slave
        end
        repeat (3) @(posedge clk_i);
        #1 rst_n_i = 1'b1;

        check_level("awvalid_o", awvalid_o, 1'b0);
        check_level("wvalid_o", wvalid_o, 1'b0);
        check_level("bready_o", bready_o, 1'b0);
        check_level("arvalid_o", arvalid_o, 1'b0);
        check_level("rready_o", rready_o, 1'b0);
        check_level("write_done_o", write_done_o, 1'b0);
        check_level("read_valid_o", read_valid_o, 1'b0);
        check_level("write_full_o", write_full_o, 1'b0);
        check_level("read_full_o", read_full_o, 1'b0);

        repeat (N_WRITES) begin
            rnd  = $random(seed);
            addr = {22'd0, rnd[7:0], 2'b00};
            written.push_back(addr);
            issue_write(addr, $random(seed), rnd[11:8]);
        end
        wait_writes();

        foreach (written[i]) issue_read(written[i]);
        wait_reads();

        // error writes alias a word inside the memory, which must stay as it was
        repeat (N_ERRORS) begin
            rnd  = $random(seed);
            addr = {rnd[31:10] | 22'd1, rnd[7:0], 2'b00};
            err_addrs.push_back(addr);
            issue_write(addr, $random(seed), 4'hf);
        end
        wait_writes();
        foreach (err_addrs[i]) begin
            issue_read(err_addrs[i]);
            issue_read({22'd0, err_addrs[i][9:2], 2'b00});
        end
        wait_reads();

        // stalled slave, fill the write queue
        burst = 0;
        step();
        stall = 1'b1;
        while (!write_full_o && burst <= axi_pkg::BUFFER_DEPTH) begin
            rnd = $random(seed);
            drive_write({22'd0, rnd[7:0], 2'b00}, $random(seed), rnd[11:8]);
            burst++;
            step();
        end
        check_level("write_full_o", write_full_o, 1'b1);
        stall = 1'b0;
        wait_writes();

        repeat (20) step();   // room for any stray pulse
        if (wr_done != wr_issued || rd_done != rd_issued) begin
            abort_run("done pulse count does not match the requests issued");
        end else begin
            $display("Testbench passed");
            $finish;
        end
    end

endmodule

// File: tb_axi_slave.sv
`timescale 1ns/1ns

module tb_axi_slave #(
    parameter int MEM_WORDS = 256,
    parameter int SEED      = 1
) (
    input  logic           clk_i,
    input  logic           rst_n_i,
    input  logic           stall_i,   // holds every ready low

    input  axi_pkg::addr_t awaddr_i,
    input  logic           awvalid_i,
    output logic           awready_o,
    input  axi_pkg::data_t wdata_i,
    input  axi_pkg::strb_t wstrb_i,
    input  logic           wvalid_i,
    output logic           wready_o,
    output logic           bvalid_o,
    output axi_pkg::resp_t bresp_o,
    input  logic           bready_i,

    input  axi_pkg::addr_t araddr_i,
    input  logic           arvalid_i,
    output logic           arready_o,
    output logic           rvalid_o,
    output axi_pkg::data_t rdata_o,
    output axi_pkg::resp_t rresp_o,
    input  logic           rready_i
);

    localparam int             IDX_W    = $clog2(MEM_WORDS);
    localparam axi_pkg::addr_t ERR_BASE = MEM_WORDS * 4;   // first byte past the memory

    axi_pkg::data_t mem [MEM_WORDS];
    integer         seed = SEED;
    logic [31:0]    rnd;
    logic [1:0]     aw_cnt;
    logic [1:0]     aw_delay;
    logic [1:0]     w_cnt;
    logic [1:0]     w_delay;
    logic [1:0]     ar_cnt;
    logic [1:0]     ar_delay;
    logic           aw_got;
    logic           w_got;
    axi_pkg::addr_t aw_addr;
    axi_pkg::data_t w_data;
    axi_pkg::strb_t w_strb;

    // ready follows valid once the drawn delay has passed
    assign awready_o = awvalid_i && !aw_got && !stall_i && (aw_cnt >= aw_delay);
    assign wready_o  = wvalid_i && !w_got && !stall_i && (w_cnt >= w_delay);
    assign arready_o = arvalid_i && !rvalid_o && !stall_i && (ar_cnt >= ar_delay);

    always @(posedge clk_i) begin
        rnd = $random(seed);
        if (!rst_n_i) begin
            for (int i = 0; i < MEM_WORDS; i++) begin
                mem[i] <= {16'hc0de, i[7:0], ~i[7:0]};
            end
            aw_cnt   <= 2'd0;
            w_cnt    <= 2'd0;
            ar_cnt   <= 2'd0;
            aw_delay <= 2'd0;
            w_delay  <= 2'd0;
            ar_delay <= 2'd0;
            aw_got   <= 1'b0;
            w_got    <= 1'b0;
            bvalid_o <= 1'b0;
            rvalid_o <= 1'b0;
        end else begin
            if (awvalid_i && awready_o) begin
                aw_got   <= 1'b1;
                aw_addr  <= awaddr_i;
                aw_cnt   <= 2'd0;
                aw_delay <= rnd[1:0];
            end else if (awvalid_i && !aw_got && aw_cnt != 2'd3) begin
                aw_cnt <= aw_cnt + 2'd1;
            end
            if (wvalid_i && wready_o) begin
                w_got   <= 1'b1;
                w_data  <= wdata_i;
                w_strb  <= wstrb_i;
                w_cnt   <= 2'd0;
                w_delay <= rnd[3:2];
            end else if (wvalid_i && !w_got && w_cnt != 2'd3) begin
                w_cnt <= w_cnt + 2'd1;
            end
            if (aw_got && w_got && !bvalid_o) begin   // both halves in, commit
                aw_got   <= 1'b0;
                w_got    <= 1'b0;
                bvalid_o <= 1'b1;
                if (aw_addr >= ERR_BASE) begin
                    bresp_o <= axi_pkg::RESP_SLVERR;
                end else begin
                    bresp_o <= axi_pkg::RESP_OKAY;
                    for (int b = 0; b < 4; b++) begin
                        if (w_strb[b]) mem[aw_addr[2 +: IDX_W]][8*b +: 8] <= w_data[8*b +: 8];
                    end
                end
            end
            if (bvalid_o && bready_i) bvalid_o <= 1'b0;

            if (arvalid_i && arready_o) begin
                rvalid_o <= 1'b1;
                ar_cnt   <= 2'd0;
                ar_delay <= rnd[5:4];
                if (araddr_i >= ERR_BASE) begin
                    rresp_o <= axi_pkg::RESP_SLVERR;
                    rdata_o <= '0;
                end else begin
                    rresp_o <= axi_pkg::RESP_OKAY;
                    rdata_o <= mem[araddr_i[2 +: IDX_W]];
                end
            end else if (arvalid_i && !rvalid_o && ar_cnt != 2'd3) begin
                ar_cnt <= ar_cnt + 2'd1;
            end
            if (rvalid_o && rready_i) rvalid_o <= 1'b0;
        end
    end

endmodule

// File: axi_master.sv
`timescale 1ns/1ns

module axi_master (
    input  logic           clk_i,
    input  logic           rst_n_i,

    // user side
    input  axi_pkg::addr_t write_address_i,
    input  axi_pkg::data_t write_data_i,
    input  axi_pkg::strb_t write_strobe_i,
    input  logic           write_load_i,
    output logic           write_full_o,
    output logic           write_done_o,
    output axi_pkg::resp_t write_resp_o,

    input  axi_pkg::addr_t read_address_i,
    input  logic           read_load_i,
    output logic           read_full_o,
    output logic           read_valid_o,
    output axi_pkg::data_t read_data_o,
    output axi_pkg::resp_t read_resp_o,

    // AXI4-Lite
    output axi_pkg::addr_t awaddr_o,
    output logic           awvalid_o,
    input  logic           awready_i,
    output axi_pkg::data_t wdata_o,
    output axi_pkg::strb_t wstrb_o,
    output logic           wvalid_o,
    input  logic           wready_i,
    input  logic           bvalid_i,
    input  axi_pkg::resp_t bresp_i,
    output logic           bready_o,
    output axi_pkg::addr_t araddr_o,
    output logic           arvalid_o,
    input  logic           arready_i,
    input  logic           rvalid_i,
    input  axi_pkg::data_t rdata_i,
    input  axi_pkg::resp_t rresp_i,
    output logic           rready_o
);

    axi_pkg::addr_t write_address;   // queue head
    axi_pkg::data_t write_data;
    axi_pkg::strb_t write_strobe;
    logic           write_start;
    logic           write_cts;

    axi_pkg::addr_t read_address;
    logic           read_start;
    logic           read_cts;

    axi_master_driver i_driver (
        .clk_i           (clk_i),
        .rst_n_i         (rst_n_i),
        .write_address_i (write_address_i),
        .write_data_i    (write_data_i),
        .write_strobe_i  (write_strobe_i),
        .write_load_i    (write_load_i),
        .write_address_o (write_address),
        .write_data_o    (write_data),
        .write_strobe_o  (write_strobe),
        .write_start_o   (write_start),
        .write_full_o    (write_full_o),
        .write_cts_i     (write_cts),
        .read_address_i  (read_address_i),
        .read_load_i     (read_load_i),
        .read_address_o  (read_address),
        .read_start_o    (read_start),
        .read_full_o     (read_full_o),
        .read_cts_i      (read_cts)
    );

    axi_write_channel i_write_channel (
        .clk_i           (clk_i),
        .rst_n_i         (rst_n_i),
        .start_address_i (write_address),
        .start_data_i    (write_data),
        .start_strobe_i  (write_strobe),
        .start_i         (write_start),
        .cts_o           (write_cts),
        .awaddr_o        (awaddr_o),
        .awvalid_o       (awvalid_o),
        .awready_i       (awready_i),
        .wdata_o         (wdata_o),
        .wstrb_o         (wstrb_o),
        .wvalid_o        (wvalid_o),
        .wready_i        (wready_i),
        .bvalid_i        (bvalid_i),
        .bresp_i         (bresp_i),
        .bready_o        (bready_o),
        .done_o          (write_done_o),
        .resp_o          (write_resp_o)
    );

    axi_read_channel i_read_channel (
        .clk_i           (clk_i),
        .rst_n_i         (rst_n_i),
        .start_address_i (read_address),
        .start_i         (read_start),
        .cts_o           (read_cts),
        .araddr_o        (araddr_o),
        .arvalid_o       (arvalid_o),
        .arready_i       (arready_i),
        .rvalid_i        (rvalid_i),
        .rdata_i         (rdata_i),
        .rresp_i         (rresp_i),
        .rready_o        (rready_o),
        .valid_o         (read_valid_o),
        .data_o          (read_data_o),
        .resp_o          (read_resp_o)
    );

endmodule

// File: axi_read_channel.sv
`timescale 1ns/1ns

module axi_read_channel (
    input  logic           clk_i,
    input  logic           rst_n_i,

    input  axi_pkg::addr_t start_address_i,
    input  logic           start_i,
    output logic           cts_o,

    output axi_pkg::addr_t araddr_o,
    output logic           arvalid_o,
    input  logic           arready_i,

    input  logic           rvalid_i,
    input  axi_pkg::data_t rdata_i,
    input  axi_pkg::resp_t rresp_i,
    output logic           rready_o,

    output logic           valid_o,
    output axi_pkg::data_t data_o,
    output axi_pkg::resp_t resp_o
);

    axi_pkg::rd_state_t state;

    assign cts_o = (state == axi_pkg::RD_IDLE);

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state     <= axi_pkg::RD_IDLE;
            arvalid_o <= 1'b0;
            rready_o  <= 1'b0;
            valid_o   <= 1'b0;
        end else begin
            valid_o <= 1'b0;
            case (state)
                axi_pkg::RD_IDLE: begin
                    if (start_i) begin
                        arvalid_o <= 1'b1;
                        state     <= axi_pkg::RD_ADDR;
                    end
                end
                axi_pkg::RD_ADDR: begin
                    if (arready_i) begin
                        arvalid_o <= 1'b0;
                        rready_o  <= 1'b1;
                        state     <= axi_pkg::RD_DATA;
                    end
                end
                axi_pkg::RD_DATA: begin
                    if (rvalid_i) begin
                        rready_o <= 1'b0;
                        valid_o  <= 1'b1;
                        state    <= axi_pkg::RD_IDLE;
                    end
                end
                default: state <= axi_pkg::RD_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (start_i) araddr_o <= start_address_i;
        if (rvalid_i && rready_o) begin   // R transfer
            data_o <= rdata_i;
            resp_o <= rresp_i;
        end
    end

    // only one read outstanding, so R is accepted in RD_DATA alone
    a_rready_in_data: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        rready_o |-> state == axi_pkg::RD_DATA);

endmodule

// File: axi_write_channel.sv
`timescale 1ns/1ns

module axi_write_channel (
    input  logic           clk_i,
    input  logic           rst_n_i,

    input  axi_pkg::addr_t start_address_i,
    input  axi_pkg::data_t start_data_i,
    input  axi_pkg::strb_t start_strobe_i,
    input  logic           start_i,
    output logic           cts_o,

    output axi_pkg::addr_t awaddr_o,
    output logic           awvalid_o,
    input  logic           awready_i,

    output axi_pkg::data_t wdata_o,
    output axi_pkg::strb_t wstrb_o,
    output logic           wvalid_o,
    input  logic           wready_i,

    input  logic           bvalid_i,
    input  axi_pkg::resp_t bresp_i,
    output logic           bready_o,

    output logic           done_o,
    output axi_pkg::resp_t resp_o
);

    axi_pkg::wr_state_t state;
    logic               aw_pending;   // AW still waiting after this edge
    logic               w_pending;

    assign cts_o = (state == axi_pkg::WR_IDLE);

    // slave may take AW and W in either order, or together
    assign aw_pending = awvalid_o && !awready_i;
    assign w_pending  = wvalid_o && !wready_i;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state     <= axi_pkg::WR_IDLE;
            awvalid_o <= 1'b0;
            wvalid_o  <= 1'b0;
            bready_o  <= 1'b0;
            done_o    <= 1'b0;
        end else begin
            done_o <= 1'b0;
            case (state)
                axi_pkg::WR_IDLE: begin
                    if (start_i) begin
                        awvalid_o <= 1'b1;
                        wvalid_o  <= 1'b1;
                        state     <= axi_pkg::WR_ADDR_DATA;
                    end
                end
                axi_pkg::WR_ADDR_DATA: begin
                    if (awready_i) awvalid_o <= 1'b0;
                    if (wready_i) wvalid_o <= 1'b0;
                    if (!aw_pending && !w_pending) begin
                        bready_o <= 1'b1;
                        state    <= axi_pkg::WR_RESP;
                    end
                end
                axi_pkg::WR_RESP: begin
                    if (bvalid_i) begin
                        bready_o <= 1'b0;
                        done_o   <= 1'b1;   // one cycle, with resp_o
                        state    <= axi_pkg::WR_IDLE;
                    end
                end
                default: state <= axi_pkg::WR_IDLE;
            endcase
        end
    end

    // request payload and response
    always_ff @(posedge clk_i) begin
        if (start_i) begin
            awaddr_o <= start_address_i;
            wdata_o  <= start_data_i;
            wstrb_o  <= start_strobe_i;
        end
        if (bvalid_i && bready_o) resp_o <= bresp_i;
    end

    a_awaddr_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        awvalid_o && !awready_i |=> awvalid_o && $stable(awaddr_o));

endmodule

// File: axi_master_driver.sv
`timescale 1ns/1ns

module axi_master_driver (
    input  logic           clk_i,
    input  logic           rst_n_i,

    input  axi_pkg::addr_t write_address_i,
    input  axi_pkg::data_t write_data_i,
    input  axi_pkg::strb_t write_strobe_i,
    input  logic           write_load_i,

    output axi_pkg::addr_t write_address_o,
    output axi_pkg::data_t write_data_o,
    output axi_pkg::strb_t write_strobe_o,
    output logic           write_start_o,
    output logic           write_full_o,
    input  logic           write_cts_i,

    input  axi_pkg::addr_t read_address_i,
    input  logic           read_load_i,

    output axi_pkg::addr_t read_address_o,
    output logic           read_start_o,
    output logic           read_full_o,
    input  logic           read_cts_i
);

    axi_pkg::ptr_t  write_push_ptr;
    axi_pkg::ptr_t  write_pull_ptr;
    axi_pkg::ptr_t  write_inc_push_ptr;
    axi_pkg::ptr_t  write_inc_pull_ptr;
    logic           write_empty;

    axi_pkg::addr_t write_addr_mem [axi_pkg::BUFFER_DEPTH];
    axi_pkg::data_t write_data_mem [axi_pkg::BUFFER_DEPTH];
    axi_pkg::strb_t write_strb_mem [axi_pkg::BUFFER_DEPTH];

    axi_pkg::ptr_t  read_push_ptr;
    axi_pkg::ptr_t  read_pull_ptr;
    axi_pkg::ptr_t  read_inc_push_ptr;
    axi_pkg::ptr_t  read_inc_pull_ptr;
    logic           read_empty;

    axi_pkg::addr_t read_addr_mem [axi_pkg::BUFFER_DEPTH];

    assign write_inc_push_ptr = write_push_ptr + axi_pkg::ptr_t'(1);
    assign write_inc_pull_ptr = write_pull_ptr + axi_pkg::ptr_t'(1);

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            write_push_ptr <= '0;
            write_pull_ptr <= '0;
        end else begin
            if (write_load_i) write_push_ptr <= write_inc_push_ptr;
            if (write_start_o) write_pull_ptr <= write_inc_pull_ptr;
        end
    end

    always_ff @(posedge clk_i) begin
        if (write_load_i) begin
            write_addr_mem[write_push_ptr] <= write_address_i;
            write_data_mem[write_push_ptr] <= write_data_i;
            write_strb_mem[write_push_ptr] <= write_strobe_i;
        end
    end

    // head entry, read straight from the array
    assign write_address_o = write_addr_mem[write_pull_ptr];
    assign write_data_o    = write_data_mem[write_pull_ptr];
    assign write_strobe_o  = write_strb_mem[write_pull_ptr];

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            write_full_o <= 1'b0;
            write_empty  <= 1'b1;
        end else begin
            case ({write_load_i, write_start_o})
                axi_pkg::FIFO_PULL: begin
                    write_full_o <= 1'b0;
                    write_empty  <= (write_push_ptr == write_inc_pull_ptr);
                end
                axi_pkg::FIFO_PUSH: begin
                    write_full_o <= (write_pull_ptr == write_inc_push_ptr);
                    write_empty  <= 1'b0;
                end
                default: ;   // idle or load and pop together
            endcase
        end
    end

    assign write_start_o = write_cts_i && !write_empty;

    assign read_inc_push_ptr = read_push_ptr + axi_pkg::ptr_t'(1);
    assign read_inc_pull_ptr = read_pull_ptr + axi_pkg::ptr_t'(1);

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            read_push_ptr <= '0;
            read_pull_ptr <= '0;
        end else begin
            if (read_load_i) read_push_ptr <= read_inc_push_ptr;
            if (read_start_o) read_pull_ptr <= read_inc_pull_ptr;
        end
    end

    always_ff @(posedge clk_i) begin
        if (read_load_i) read_addr_mem[read_push_ptr] <= read_address_i;
    end

    assign read_address_o = read_addr_mem[read_pull_ptr];

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            read_full_o <= 1'b0;
            read_empty  <= 1'b1;
        end else begin
            case ({read_load_i, read_start_o})
                axi_pkg::FIFO_PULL: begin
                    read_full_o <= 1'b0;
                    read_empty  <= (read_push_ptr == read_inc_pull_ptr);
                end
                axi_pkg::FIFO_PUSH: begin
                    read_full_o <= (read_pull_ptr == read_inc_push_ptr);
                    read_empty  <= 1'b0;
                end
                default: ;
            endcase
        end
    end

    assign read_start_o = read_cts_i && !read_empty;

    // user side must respect the full levels
    a_write_no_load_full: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        write_load_i |-> !write_full_o);
    a_read_no_load_full: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        read_load_i |-> !read_full_o);

    // pointers equal means empty unless the full flag says otherwise
    a_write_no_start_empty: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        write_start_o |-> (write_push_ptr != write_pull_ptr) || write_full_o);
    a_read_no_start_empty: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        read_start_o |-> (read_push_ptr != read_pull_ptr) || read_full_o);

endmodule

// File: axi_pkg.sv
package axi_pkg;

    // bus widths
    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;
    localparam int STRB_W = DATA_W / 8;
    localparam int RESP_W = 2;

    // request queue depth, same for the write and the read side
    localparam int BUFFER_DEPTH = 128;
    localparam int PTR_W        = $clog2(BUFFER_DEPTH);

    typedef logic [ADDR_W-1:0] addr_t;   // byte address
    typedef logic [DATA_W-1:0] data_t;
    typedef logic [STRB_W-1:0] strb_t;   // one bit per byte lane
    typedef logic [RESP_W-1:0] resp_t;
    typedef logic [PTR_W-1:0]  ptr_t;    // wraps at BUFFER_DEPTH

    // xRESP encodings
    localparam resp_t RESP_OKAY   = 2'b00;
    localparam resp_t RESP_SLVERR = 2'b10;

    // fifo access mode, indexed as {load, start}
    localparam logic [1:0] FIFO_PULL = 2'b01;
    localparam logic [1:0] FIFO_PUSH = 2'b10;

    // write engine
    typedef enum logic [1:0] {
        WR_IDLE,        // clear to send
        WR_ADDR_DATA,   // AW and W in flight
        WR_RESP         // waiting for B
    } wr_state_t;

    // read engine
    typedef enum logic [1:0] {
        RD_IDLE,
        RD_ADDR,        // AR in flight
        RD_DATA         // waiting for R
    } rd_state_t;

endpackage
